// File: verilog.f
verilog/video_pkg.sv
verilog/input_pkg.sv
verilog/ps2_receiver.sv
verilog/key_decoder.sv
verilog/game_control.sv
verilog/vga_timing.sv
verilog/pixel_renderer.sv
verilog/seven_seg.sv
verilog/game_top.sv
tests/tb_game_top.sv

// File: run.sh
#!/bin/sh
# builds the keyboard box game testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_game_top -f verilog.f -o sim_game_top

./obj_dir/sim_game_top

// File: tests/tb_game_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_game_top;

	localparam int H_ACTIVE = 32;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 4;
	localparam int H_BACK   = 2;
	localparam int V_ACTIVE = 24;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 1;
	localparam int BOX_SIZE = 4;
	localparam int STEP     = 2;

	localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int CLK_PERIOD  = 40;
	localparam int PS2_HALF    = 5;
	localparam int WATCHDOG_NS = 40 * H_TOTAL * V_TOTAL * CLK_PERIOD;
	localparam int START_X     = H_ACTIVE / 2 - BOX_SIZE / 2;
	localparam int START_Y     = V_ACTIVE / 2 - BOX_SIZE / 2;
	localparam int X_MAX       = H_ACTIVE - BOX_SIZE;
	localparam video_pkg::rgb_t BLACK_RGB = '0;

	logic       clk;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_data;
	logic [7:0] vga_r, vga_g, vga_b;
	logic       vga_hs, vga_vs, vga_blank_n;
	logic [6:0] hex0, hex1;

	// screen tracker state
	video_pkg::rgb_t   pix;
	logic              tracking = 1'b0;
	logic              prev_blank_n = 1'b1;
	logic              prev_vs = 1'b1;
	int                px, py, frame_count = 0;
	int                min_x, max_x, min_y, max_y, box_pixels;
	video_pkg::coord_t rec_x, rec_y;
	int                rec_w, rec_h, rec_pixels;

	game_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.BOX_SIZE(BOX_SIZE), .STEP(STEP)
	) dut (
		.i_clk(clk), .i_reset(reset), .i_ps2_clk(ps2_clk), .i_ps2_data(ps2_data),
		.o_vga_r(vga_r), .o_vga_g(vga_g), .o_vga_b(vga_b),
		.o_vga_hs(vga_hs), .o_vga_vs(vga_vs), .o_vga_blank_n(vga_blank_n),
		.o_hex0(hex0), .o_hex1(hex1)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_rgb(input string name, input video_pkg::rgb_t got,
			input video_pkg::rgb_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_code(input string name, input input_pkg::scan_code_t got,
			input input_pkg::scan_code_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_coord(input string name, input video_pkg::coord_t got,
			input video_pkg::coord_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	// active-low digit with bit 0 as segment a
	function automatic int seg_to_nibble(input logic [6:0] seg);
		case (seg)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0010000: return 9;
			7'b0001000: return 10;
			7'b0000011: return 11;
			7'b1000110: return 12;
			7'b0100001: return 13;
			7'b0000110: return 14;
			7'b0001110: return 15;
			default:    return -1;
		endcase
	endfunction

	task automatic read_hex(output input_pkg::scan_code_t shown);
		int hi;
		int lo;
		hi = seg_to_nibble(hex1);
		lo = seg_to_nibble(hex0);
		if (hi < 0 || lo < 0) begin
			fail_run($sformatf("seven-segment digits show no hex pattern at %0t", $time));
		end
		shown = input_pkg::scan_code_t'(hi * 16 + lo);
	endtask

	// the pipeline needs a handful of cycles after the stop bit
	task automatic wait_hex(input input_pkg::scan_code_t exp);
		input_pkg::scan_code_t shown;
		int n;
		n = 0;
		read_hex(shown);
		while (shown !== exp && n < 20) begin
			@(negedge clk);
			n++;
			read_hex(shown);
		end
		check_code("hex display", shown, exp);
	endtask

	task automatic send_ps2_byte(input input_pkg::scan_code_t code, input bit good_parity);
		logic [10:0] frame;
		logic parity;
		parity = ~^code;
		if (!good_parity) begin
			parity = ~parity;
		end
		frame = {1'b1, parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		repeat (PS2_HALF) @(negedge clk);
	endtask

	task automatic clear_spans();
		min_x = H_TOTAL;
		min_y = V_TOTAL;
		max_x = -1;
		max_y = -1;
		box_pixels = 0;
	endtask

	task automatic close_frame();
		if (box_pixels == 0) begin
			fail_run($sformatf("no box pixels seen in the frame ending at %0t", $time));
		end
		rec_x = video_pkg::coord_t'(min_x);
		rec_y = video_pkg::coord_t'(min_y);
		rec_w = max_x - min_x + 1;
		rec_h = max_y - min_y + 1;
		rec_pixels = box_pixels;
		clear_spans();
		frame_count++;
	endtask

	// rebuilds x and y from blank_n and vsync with one sample per pixel
	always @(negedge clk) begin
		pix = {vga_r, vga_g, vga_b};
		if (reset) begin
			tracking = 1'b0;
		end else if (tracking) begin
			if (vga_blank_n) begin
				if (pix == video_pkg::BOX_COLOR) begin
					min_x = (px < min_x) ? px : min_x;
					max_x = (px > max_x) ? px : max_x;
					min_y = (py < min_y) ? py : min_y;
					max_y = (py > max_y) ? py : max_y;
					box_pixels++;
				end else begin
					check_rgb("background pixel", pix, video_pkg::BG_COLOR);
				end
				px++;
			end else begin
				check_rgb("blanking pixel", pix, BLACK_RGB);
				if (prev_blank_n) begin
					check_count("active pixels per line", px, H_ACTIVE);
					px = 0;
					py++;
					if (py == V_ACTIVE) begin
						close_frame();
					end
				end
			end
			if (prev_vs && !vga_vs) begin
				check_count("active lines per frame", py, V_ACTIVE);
				py = 0;
			end
		end else if (prev_vs && !vga_vs) begin
			tracking = 1'b1;
			px = 0;
			py = 0;
			clear_spans();
		end
		prev_blank_n = vga_blank_n;
		prev_vs = vga_vs;
	end

	task automatic wait_frame();
		int start;
		start = frame_count;
		while (frame_count == start) begin
			@(negedge clk);
		end
	endtask

	task automatic check_box(input int exp_x, input int exp_y);
		check_coord("box x", rec_x, video_pkg::coord_t'(exp_x));
		check_coord("box y", rec_y, video_pkg::coord_t'(exp_y));
		check_count("box width", rec_w, BOX_SIZE);
		check_count("box height", rec_h, BOX_SIZE);
		check_count("box pixels", rec_pixels, BOX_SIZE * BOX_SIZE);
	endtask

	// one step per frame until the edge where the box then rests
	task automatic follow_motion(input bit along_x, input int start, input int delta,
			input int limit, input int fixed);
		int exp;
		int pos;
		wait_frame();
		pos = along_x ? int'(rec_x) : int'(rec_y);
		exp = start;
		// the key may land before or after this frame's tick
		if (pos == start + delta) begin
			exp = start + delta;
		end
		check_box(along_x ? exp : fixed, along_x ? fixed : exp);
		while (exp != limit) begin
			exp = exp + delta;
			if ((delta > 0 && exp > limit) || (delta < 0 && exp < limit)) begin
				exp = limit;
			end
			wait_frame();
			check_box(along_x ? exp : fixed, along_x ? fixed : exp);
		end
		wait_frame();
		check_box(along_x ? exp : fixed, along_x ? fixed : exp);
	endtask

	function automatic logic sync_level(input bit vertical);
		return vertical ? vga_vs : vga_hs;
	endfunction

	task automatic wait_sync_fall(input bit vertical);
		logic prev;
		prev = sync_level(vertical);
		@(negedge clk);
		while (!(prev && !sync_level(vertical))) begin
			prev = sync_level(vertical);
			@(negedge clk);
		end
	endtask

	task automatic measure_sync(input bit vertical, output int low_len, output int period);
		wait_sync_fall(vertical);
		low_len = 0;
		period = 0;
		while (!sync_level(vertical)) begin
			low_len++;
			period++;
			@(negedge clk);
		end
		while (sync_level(vertical)) begin
			period++;
			@(negedge clk);
		end
	endtask

	task automatic reset_state();
		input_pkg::scan_code_t shown;
		read_hex(shown);
		check_code("hex display", shown, 8'h00);
		wait_frame();
		check_box(START_X, START_Y);
		wait_frame();
		check_box(START_X, START_Y);
	endtask

	// blank_n per line and per frame is counted by the tracker
	task automatic sync_timing();
		int low_len;
		int period;
		for (int i = 0; i < 3; i++) begin
			measure_sync(1'b0, low_len, period);
			check_count("hsync low clocks", low_len, H_SYNC);
			check_count("hsync period", period, H_TOTAL);
		end
		measure_sync(1'b1, low_len, period);
		check_count("vsync low clocks", low_len, V_SYNC * H_TOTAL);
		check_count("vsync period", period, V_TOTAL * H_TOTAL);
	endtask

	task automatic right_arrow_press();
		send_ps2_byte(input_pkg::CODE_EXT, 1'b1);
		send_ps2_byte(input_pkg::CODE_RIGHT, 1'b1);
		wait_hex(8'h74);
		follow_motion(1'b1, START_X, STEP, X_MAX, START_Y);
	endtask

	task automatic release_stops_motion();
		input_pkg::scan_code_t shown;
		send_ps2_byte(input_pkg::CODE_EXT, 1'b1);
		send_ps2_byte(input_pkg::CODE_BREAK, 1'b1);
		send_ps2_byte(input_pkg::CODE_RIGHT, 1'b1);
		wait_frame();
		read_hex(shown);
		check_code("hex display", shown, 8'h74);
		for (int i = 0; i < 3; i++) begin
			wait_frame();
			check_box(X_MAX, START_Y);
		end
	endtask

	task automatic corrupt_frame_ignored();
		input_pkg::scan_code_t shown;
		int gap;
		// a good prefix followed by an up code with broken parity
		send_ps2_byte(input_pkg::CODE_EXT, 1'b1);
		send_ps2_byte(input_pkg::CODE_UP, 1'b0);
		gap = $urandom_range(40, 400);
		repeat (gap) @(negedge clk);
		read_hex(shown);
		check_code("hex display", shown, 8'h74);
		wait_frame();
		check_box(X_MAX, START_Y);
		wait_frame();
		check_box(X_MAX, START_Y);
		send_ps2_byte(input_pkg::CODE_EXT, 1'b1);
		send_ps2_byte(input_pkg::CODE_UP, 1'b1);
		wait_hex(8'h75);
		follow_motion(1'b0, START_Y, -STEP, 0, X_MAX);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		void'($urandom(32'hb452_1b3c));
		repeat (5) @(negedge clk);
		reset = 1'b0;
		reset_state();
		sync_timing();
		right_arrow_press();
		release_stops_motion();
		corrupt_frame_ignored();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// File: verilog/game_top.sv
`timescale 1ns/1ns
`default_nettype none

module game_top #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33,
	parameter int BOX_SIZE = 16,
	parameter int STEP     = 4
) (
	input  wire         i_clk,
	input  wire         i_reset,
	input  wire         i_ps2_clk,
	input  wire         i_ps2_data,
	output logic [7:0]  o_vga_r,
	output logic [7:0]  o_vga_g,
	output logic [7:0]  o_vga_b,
	output logic        o_vga_hs,
	output logic        o_vga_vs,
	output logic        o_vga_blank_n,
	output logic [6:0]  o_hex0,
	output logic [6:0]  o_hex1
);

	// keyboard path
	input_pkg::scan_code_t  rx_byte;
	logic                   rx_valid;
	logic                   rx_ready;
	input_pkg::arrow_t      ev_key;
	logic                   ev_pressed;
	input_pkg::scan_code_t  ev_code;
	logic                   ev_valid;
	logic                   ev_ready;
	input_pkg::scan_code_t  last_code;

	// video path
	video_pkg::coord_t  x, y;
	video_pkg::coord_t  box_x, box_y;
	logic               active, hsync, vsync, frame_tick;
	video_pkg::rgb_t    rgb;

	ps2_receiver ps2_rx0 (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ps2_clk(i_ps2_clk),
		.i_ps2_data(i_ps2_data),
		.o_byte(rx_byte),
		.o_byte_valid(rx_valid),
		.i_byte_ready(rx_ready)
	);

	key_decoder key_dec0 (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_byte(rx_byte),
		.i_byte_valid(rx_valid),
		.o_byte_ready(rx_ready),
		.o_key(ev_key),
		.o_pressed(ev_pressed),
		.o_code(ev_code),
		.o_event_valid(ev_valid),
		.i_event_ready(ev_ready)
	);

	game_control #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.BOX_SIZE(BOX_SIZE),
		.STEP(STEP)
	) game0 (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_key(ev_key),
		.i_pressed(ev_pressed),
		.i_code(ev_code),
		.i_event_valid(ev_valid),
		.o_event_ready(ev_ready),
		.i_frame_tick(frame_tick),
		.o_box_x(box_x),
		.o_box_y(box_y),
		.o_last_code(last_code)
	);

	vga_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) vga0 (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.o_x(x),
		.o_y(y),
		.o_active(active),
		.o_hsync(hsync),
		.o_vsync(vsync),
		.o_frame_tick(frame_tick)
	);

	pixel_renderer #(
		.BOX_SIZE(BOX_SIZE)
	) render0 (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_x(x),
		.i_y(y),
		.i_active(active),
		.i_hsync(hsync),
		.i_vsync(vsync),
		.i_box_x(box_x),
		.i_box_y(box_y),
		.o_rgb(rgb),
		.o_hsync(o_vga_hs),
		.o_vsync(o_vga_vs),
		.o_blank_n(o_vga_blank_n)
	);

	assign o_vga_r = rgb.r;
	assign o_vga_g = rgb.g;
	assign o_vga_b = rgb.b;

	// hex1 shows the high nibble
	seven_seg seven_dec0 (
		.i_code(last_code),
		.o_seg_hi(o_hex1),
		.o_seg_lo(o_hex0)
	);

endmodule

`default_nettype wire

// File: verilog/seven_seg.sv
`timescale 1ns/1ns
`default_nettype none

module seven_seg (
	input  input_pkg::scan_code_t   i_code,
	output logic [6:0]              o_seg_hi,
	output logic [6:0]              o_seg_lo
);

	// segments g..a, a lit segment is 0
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	assign o_seg_hi = hex_to_seg(i_code[7:4]);
	assign o_seg_lo = hex_to_seg(i_code[3:0]);

endmodule

`default_nettype wire

// File: verilog/pixel_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_renderer #(
	parameter int BOX_SIZE = 16
) (
	input  wire                 i_clk,
	input  wire                 i_reset,
	input  video_pkg::coord_t   i_x,
	input  video_pkg::coord_t   i_y,
	input  wire                 i_active,
	input  wire                 i_hsync,
	input  wire                 i_vsync,
	input  video_pkg::coord_t   i_box_x,
	input  video_pkg::coord_t   i_box_y,
	output video_pkg::rgb_t     o_rgb,
	output logic                o_hsync,
	output logic                o_vsync,
	output logic                o_blank_n
);

	localparam video_pkg::coord_t SIZE = video_pkg::coord_t'(BOX_SIZE);

	logic in_box;

	assign in_box = (i_x >= i_box_x) && (i_x < i_box_x + SIZE) &&
	                (i_y >= i_box_y) && (i_y < i_box_y + SIZE);

	// colour goes through the same stage as the syncs
	always_ff @(posedge i_clk) begin
		if (!i_active) begin
			o_rgb <= video_pkg::BLACK;
		end else if (in_box) begin
			o_rgb <= video_pkg::BOX_COLOR;
		end else begin
			o_rgb <= video_pkg::BG_COLOR;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_hsync   <= 1'b1;
			o_vsync   <= 1'b1;
			o_blank_n <= 1'b1;
		end else begin
			o_hsync   <= i_hsync;
			o_vsync   <= i_vsync;
			o_blank_n <= i_active;
		end
	end

endmodule

`default_nettype wire

// File: verilog/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  wire                 i_clk,
	input  wire                 i_reset,
	output video_pkg::coord_t   o_x,
	output video_pkg::coord_t   o_y,
	output logic                o_active,
	output logic                o_hsync,
	output logic                o_vsync,
	output logic                o_frame_tick
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam video_pkg::coord_t H_LAST   = video_pkg::coord_t'(H_TOTAL - 1);
	localparam video_pkg::coord_t V_LAST   = video_pkg::coord_t'(V_TOTAL - 1);
	localparam video_pkg::coord_t H_END    = video_pkg::coord_t'(H_ACTIVE);
	localparam video_pkg::coord_t V_END    = video_pkg::coord_t'(V_ACTIVE);
	localparam video_pkg::coord_t HS_START = video_pkg::coord_t'(H_ACTIVE + H_FRONT);
	localparam video_pkg::coord_t HS_END   = video_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam video_pkg::coord_t VS_START = video_pkg::coord_t'(V_ACTIVE + V_FRONT);
	localparam video_pkg::coord_t VS_END   = video_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

	video_pkg::coord_t h_cnt;
	video_pkg::coord_t v_cnt;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign o_x      = h_cnt;
	assign o_y      = v_cnt;
	assign o_active = (h_cnt < H_END) && (v_cnt < V_END);

	// both syncs are active low
	assign o_hsync = ~((h_cnt >= HS_START) && (h_cnt < HS_END));
	assign o_vsync = ~((v_cnt >= VS_START) && (v_cnt < VS_END));

	// first pixel of the first blank line
	assign o_frame_tick = (h_cnt == '0) && (v_cnt == V_END);

	a_cnt_range: assert property (@(posedge i_clk) disable iff (i_reset)
		(int'(h_cnt) < H_TOTAL) && (int'(v_cnt) < V_TOTAL));

endmodule

`default_nettype wire

// File: verilog/game_control.sv
`timescale 1ns/1ns
`default_nettype none

module game_control #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int BOX_SIZE = 16,
	parameter int STEP     = 4
) (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  input_pkg::arrow_t       i_key,
	input  wire                     i_pressed,
	input  input_pkg::scan_code_t   i_code,
	input  wire                     i_event_valid,
	output logic                    o_event_ready,
	input  wire                     i_frame_tick,
	output video_pkg::coord_t       o_box_x,
	output video_pkg::coord_t       o_box_y,
	output input_pkg::scan_code_t   o_last_code
);

	// furthest top-left corner that keeps the box on screen
	localparam int X_MAX = H_ACTIVE - BOX_SIZE;
	localparam int Y_MAX = V_ACTIVE - BOX_SIZE;

	// start in the middle of the screen
	localparam video_pkg::coord_t X_START = video_pkg::coord_t'(H_ACTIVE / 2 - BOX_SIZE / 2);
	localparam video_pkg::coord_t Y_START = video_pkg::coord_t'(V_ACTIVE / 2 - BOX_SIZE / 2);

	logic held_up;
	logic held_down;
	logic held_left;
	logic held_right;
	logic event_fire;

	// one axis step, saturating at both edges
	function automatic video_pkg::coord_t move_axis(
		input video_pkg::coord_t pos,
		input logic              inc,
		input logic              dec,
		input int                limit
	);
		int next;
		next = int'(pos);
		if (inc) next = next + STEP;
		if (dec) next = next - STEP;
		if (next < 0) begin
			next = 0;
		end else if (next > limit) begin
			next = limit;
		end
		return video_pkg::coord_t'(next);
	endfunction

	// the frame tick cycle belongs to motion
	assign o_event_ready = ~i_frame_tick;
	assign event_fire    = i_event_valid & o_event_ready;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			held_up     <= 1'b0;
			held_down   <= 1'b0;
			held_left   <= 1'b0;
			held_right  <= 1'b0;
			o_box_x     <= X_START;
			o_box_y     <= Y_START;
			o_last_code <= 8'h00;
		end else begin
			if (event_fire) begin
				case (i_key)
					input_pkg::ARROW_UP:    held_up    <= i_pressed;
					input_pkg::ARROW_DOWN:  held_down  <= i_pressed;
					input_pkg::ARROW_LEFT:  held_left  <= i_pressed;
					input_pkg::ARROW_RIGHT: held_right <= i_pressed;
					default: ;
				endcase
				// only make codes reach the display
				if (i_pressed) begin
					o_last_code <= i_code;
				end
			end
			if (i_frame_tick) begin
				o_box_x <= move_axis(o_box_x, held_right, held_left, X_MAX);
				o_box_y <= move_axis(o_box_y, held_down, held_up, Y_MAX);
			end
		end
	end

	a_box_on_screen: assert property (@(posedge i_clk) disable iff (i_reset)
		(int'(o_box_x) <= X_MAX) && (int'(o_box_y) <= Y_MAX));

endmodule

`default_nettype wire

// File: verilog/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  input_pkg::scan_code_t   i_byte,
	input  wire                     i_byte_valid,
	output logic                    o_byte_ready,
	output input_pkg::arrow_t       o_key,
	output logic                    o_pressed,
	output input_pkg::scan_code_t   o_code,
	output logic                    o_event_valid,
	input  wire                     i_event_ready
);

	logic e0_seen;
	logic f0_seen;
	logic byte_fire;
	input_pkg::arrow_t byte_key;

	function automatic input_pkg::arrow_t to_arrow(input input_pkg::scan_code_t code);
		case (code)
			input_pkg::CODE_UP:    return input_pkg::ARROW_UP;
			input_pkg::CODE_DOWN:  return input_pkg::ARROW_DOWN;
			input_pkg::CODE_LEFT:  return input_pkg::ARROW_LEFT;
			input_pkg::CODE_RIGHT: return input_pkg::ARROW_RIGHT;
			default:               return input_pkg::ARROW_NONE;
		endcase
	endfunction

	// stall the receiver while an event waits
	assign o_byte_ready = ~o_event_valid;
	assign byte_fire    = i_byte_valid & o_byte_ready;
	assign byte_key     = to_arrow(i_byte);

	always_ff @(posedge i_clk) begin
		if (byte_fire) begin
			o_key     <= byte_key;
			o_pressed <= ~f0_seen;
			o_code    <= i_byte;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			e0_seen       <= 1'b0;
			f0_seen       <= 1'b0;
			o_event_valid <= 1'b0;
		end else begin
			if (o_event_valid && i_event_ready) begin
				o_event_valid <= 1'b0;
			end
			if (byte_fire) begin
				if (i_byte == input_pkg::CODE_EXT) begin
					e0_seen <= 1'b1;
				end else if (i_byte == input_pkg::CODE_BREAK) begin
					f0_seen <= 1'b1;
				end else begin
					// any real code ends the sequence
					e0_seen       <= 1'b0;
					f0_seen       <= 1'b0;
					o_event_valid <= e0_seen && (byte_key != input_pkg::ARROW_NONE);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/ps2_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_ps2_clk,
	input  wire                     i_ps2_data,
	output input_pkg::scan_code_t   o_byte,
	output logic                    o_byte_valid,
	input  wire                     i_byte_ready
);

	// two-flop synchronisers for both lines
	logic clk_s1, clk_s2, clk_prev;
	logic data_s1, data_s2;
	logic ps2_fall;

	// start, 8 data, parity, stop
	logic [10:0] shreg;
	logic [3:0]  bit_cnt;
	logic        frame_done;
	logic        frame_ok;
	input_pkg::scan_code_t byte_q;

	always_ff @(posedge i_clk) begin
		clk_s1   <= i_ps2_clk;
		clk_s2   <= clk_s1;
		clk_prev <= clk_s2;
		data_s1  <= i_ps2_data;
		data_s2  <= data_s1;
	end

	assign ps2_fall = clk_prev & ~clk_s2;

	// shifting is lsb first, so the start bit ends up in bit 0
	always_ff @(posedge i_clk) begin
		if (ps2_fall) begin
			shreg <= {data_s2, shreg[10:1]};
		end
		if (frame_done) begin
			byte_q <= shreg[8:1];
		end
		if (frame_ok && !o_byte_valid) begin
			o_byte <= byte_q;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			bit_cnt      <= 4'd0;
			frame_done   <= 1'b0;
			frame_ok     <= 1'b0;
			o_byte_valid <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (ps2_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= 4'd0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			// start low, odd parity over data and parity, stop high
			frame_ok <= frame_done && !shreg[0] && (^shreg[9:1]) && shreg[10];
			if (o_byte_valid && i_byte_ready) begin
				o_byte_valid <= 1'b0;
			end
			// a byte still waiting means the new frame is lost
			if (frame_ok && !o_byte_valid) begin
				o_byte_valid <= 1'b1;
			end
		end
	end

	a_byte_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_byte_valid && !i_byte_ready |=> o_byte_valid && $stable(o_byte));

endmodule

`default_nettype wire

// File: verilog/input_pkg.sv
`default_nettype none

package input_pkg;

	// one byte as it arrives from the keyboard
	typedef logic [7:0] scan_code_t;

	// arrow keys the game reacts to
	typedef enum logic [2:0] {
		ARROW_NONE,
		ARROW_UP,
		ARROW_DOWN,
		ARROW_LEFT,
		ARROW_RIGHT
	} arrow_t;

	// prefixes of set 2
	localparam scan_code_t CODE_EXT   = 8'he0;
	localparam scan_code_t CODE_BREAK = 8'hf0;

	// arrow codes, always sent after E0
	localparam scan_code_t CODE_UP    = 8'h75;
	localparam scan_code_t CODE_DOWN  = 8'h72;
	localparam scan_code_t CODE_LEFT  = 8'h6b;
	localparam scan_code_t CODE_RIGHT = 8'h74;

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

	// width of every pixel and line coordinate
	localparam int COORD_W = 10;

	// pixel or line position on screen
	typedef logic [COORD_W-1:0] coord_t;

	// one pixel, 8 bits per channel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// white box
	localparam rgb_t BOX_COLOR = '{r: 8'hff, g: 8'hff, b: 8'hff};

	// dark blue background
	localparam rgb_t BG_COLOR = '{r: 8'h00, g: 8'h00, b: 8'h60};

	// outside the active area
	localparam rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

endpackage

`default_nettype wire
